/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // address split of a 15-bit halfword address
    // tag sits in the top bits, word offset in the bottom bits
    localparam int tag_bits = 6;
    localparam int set_bits = 6;
    localparam int word_bits = 3;
    localparam int addr_bits = 15;

    // one data word per halfword
    localparam int data_bits = 16;

    // storage geometry
    localparam int num_sets = 64;
    localparam int words_per_block = 8;

    // request opcodes from the processor
    typedef enum logic {
        op_read = 1'b0,
        op_invalidate = 1'b1
    } req_op_e;

    // execute stage refill sequence
    typedef enum logic [1:0] {
        st_run = 2'd0,
        st_refill_req = 2'd1,
        st_refill_wait = 2'd2,
        st_replay = 2'd3
    } exec_state_e;

    // request as seen on the processor port
    typedef struct packed {
        req_op_e op;
        logic [addr_bits-1:0] addr;
    } cache_req_t;

    // address after the decode split
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [set_bits-1:0] set;
        logic [word_bits-1:0] word;
    } addr_fields_t;

    // meta byte of one way
    // valid in bit 7, tag in bits 6..1, lru in bit 0
    // lru set means this way is the next victim
    typedef struct packed {
        logic valid;
        logic [tag_bits-1:0] tag;
        logic lru;
    } meta_t;

    // request held in the decode register
    typedef struct packed {
        req_op_e op;
        addr_fields_t fields;
    } decoded_req_t;

    // response toward the processor
    typedef struct packed {
        logic hit;
        logic [data_bits-1:0] data;
    } cache_resp_t;

    // one word of a block refill from memory
    typedef struct packed {
        logic [word_bits-1:0] word;
        logic [data_bits-1:0] data;
    } mem_fill_t;

endpackage

`default_nettype wire

/* logic/meta_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module meta_data_array (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         write,
    input  wire logic [cache_pkg::set_bits-1:0] set_index,
    input  wire logic                         first_is_lru,
    input  cache_pkg::meta_t                  meta_in_first,
    input  cache_pkg::meta_t                  meta_in_second,
    output cache_pkg::meta_t                  meta_out_first,
    output cache_pkg::meta_t                  meta_out_second
);
    import cache_pkg::*;

    // one meta byte per way and set
    meta_t first_way [num_sets];
    meta_t second_way [num_sets];

    // both ways of a set are always written together
    // the lru bits come out complementary so exactly one way is the victim
    always_ff @(posedge clk) begin
        if (rst) begin
            // all ways invalid, tags and lru cleared
            first_way <= '{default: '0};
            second_way <= '{default: '0};
        end else if (write) begin
            first_way[set_index] <= '{
                valid: meta_in_first.valid,
                tag: meta_in_first.tag,
                lru: first_is_lru
            };
            second_way[set_index] <= '{
                valid: meta_in_second.valid,
                tag: meta_in_second.tag,
                lru: ~first_is_lru
            };
        end
    end

    // lookup is combinational so execute can compare in the same cycle
    assign meta_out_first = first_way[set_index];
    assign meta_out_second = second_way[set_index];

    // a write with an unknown index would corrupt an arbitrary set
    a_write_index_known: assert property (
        @(posedge clk) disable iff (rst)
        write |-> !$isunknown(set_index)
    );

endmodule

`default_nettype wire

/* logic/block_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module block_data_array (
    input  wire logic                            clk,
    input  wire logic                            write,
    input  wire logic                            way,
    input  wire logic [cache_pkg::set_bits-1:0]  set_index,
    input  wire logic [cache_pkg::word_bits-1:0] word,
    input  wire logic [cache_pkg::data_bits-1:0] data_in,
    output logic      [cache_pkg::data_bits-1:0] data_out_first,
    output logic      [cache_pkg::data_bits-1:0] data_out_second
);
    import cache_pkg::*;

    // data store indexed by way, set and word offset
    // contents are only meaningful once the meta byte marks the way valid
    logic [data_bits-1:0] store [2][num_sets][words_per_block];

    // refill writes one word per memory strobe into the victim way
    always_ff @(posedge clk) begin
        if (write) begin
            store[way][set_index][word] <= data_in;
        end
    end

    // both ways are read at once
    // execute picks the hitting way after the tag compare
    assign data_out_first = store[0][set_index][word];
    assign data_out_second = store[1][set_index][word];

endmodule

`default_nettype wire

/* logic/cache_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_decode (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              req_valid,
    input  cache_pkg::cache_req_t  req,
    input  wire logic              stall,
    output logic                   dec_valid,
    output cache_pkg::decoded_req_t dec_req
);
    import cache_pkg::*;

    // field boundaries inside the halfword address
    localparam int word_lo = 0;
    localparam int set_lo = word_bits;
    localparam int tag_lo = word_bits + set_bits;

    // valid bit of the request register
    // while execute stalls the held request must not be lost
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= req_valid;
        end
    end

    // request payload, split into tag, set and word
    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_req.op <= req.op;
            dec_req.fields.tag <= req.addr[tag_lo +: tag_bits];
            dec_req.fields.set <= req.addr[set_lo +: set_bits];
            dec_req.fields.word <= req.addr[word_lo +: word_bits];
        end
    end

    // the requester watches busy, which is the execute stall
    // a request during a stall would be dropped by the held register
    a_no_req_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        stall |-> !req_valid
    );

endmodule

`default_nettype wire

/* logic/cache_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_execute (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          dec_valid,
    input  cache_pkg::decoded_req_t            dec_req,
    output logic                               stall,
    output logic                               exe_valid,
    output cache_pkg::cache_resp_t             exe_resp,
    output logic                               mem_req,
    output logic [cache_pkg::tag_bits+cache_pkg::set_bits-1:0] mem_block_addr,
    input  wire logic                          mem_valid,
    input  cache_pkg::mem_fill_t               mem_fill
);
    import cache_pkg::*;

    exec_state_e state;
    // missed read, kept for refill and replay
    addr_fields_t miss_req;
    logic miss_way;
    logic [set_bits-1:0] set_index;
    logic [word_bits-1:0] word;
    meta_t meta_first, meta_second, meta_in_first, meta_in_second;
    logic meta_write, first_is_lru;
    logic [data_bits-1:0] data_first, data_second;
    logic hit_first, hit_second, hit_any, victim, last_word, run_req;

    meta_data_array u_meta (
        .clk, .rst, .write(meta_write), .set_index, .first_is_lru,
        .meta_in_first, .meta_in_second,
        .meta_out_first(meta_first), .meta_out_second(meta_second)
    );

    block_data_array u_data (
        .clk, .write(state == st_refill_wait && mem_valid), .way(miss_way),
        .set_index, .word, .data_in(mem_fill.data),
        .data_out_first(data_first), .data_out_second(data_second)
    );

    // new requests are looked up only in st_run
    assign run_req = dec_valid && state == st_run;
    assign set_index = (state == st_run) ? dec_req.fields.set : miss_req.set;
    // the fill strobe carries its own word offset
    always_comb begin
        word = (state == st_run) ? dec_req.fields.word : miss_req.word;
        if (state == st_refill_wait) word = mem_fill.word;
    end

    // tag compare against both valid ways
    assign hit_first = meta_first.valid && meta_first.tag == dec_req.fields.tag;
    assign hit_second = meta_second.valid && meta_second.tag == dec_req.fields.tag;
    assign hit_any = hit_first || hit_second;
    assign last_word = mem_valid && mem_fill.word == word_bits'(words_per_block - 1);

    // victim choice, first invalid way, then the lru way, else way 0
    always_comb begin
        if (!meta_first.valid) victim = 1'b0;
        else if (!meta_second.valid) victim = 1'b1;
        else if (meta_first.lru) victim = 1'b0;
        else if (meta_second.lru) victim = 1'b1;
        else victim = 1'b0;
    end

    // meta rewrite for hits, invalidates and the end of a refill
    always_comb begin
        meta_write = 1'b0;
        meta_in_first = meta_first;
        meta_in_second = meta_second;
        first_is_lru = meta_first.lru;
        if (run_req && dec_req.op == op_invalidate) begin
            meta_write = 1'b1;
            meta_in_first.valid = 1'b0;
            meta_in_second.valid = 1'b0;
        end else if (run_req && hit_any) begin
            // the way that did not hit becomes the victim
            meta_write = 1'b1;
            first_is_lru = hit_second;
        end else if (state == st_refill_wait && last_word) begin
            meta_write = 1'b1;
            first_is_lru = miss_way;
            if (miss_way) meta_in_second = '{valid: 1'b1, tag: miss_req.tag, lru: 1'b0};
            else meta_in_first = '{valid: 1'b1, tag: miss_req.tag, lru: 1'b0};
        end
    end

    // responses, read hits and invalidates now, misses from st_replay
    always_comb begin
        exe_valid = 1'b0;
        exe_resp = '0;
        if (state == st_replay) begin
            exe_valid = 1'b1;
            exe_resp.data = miss_way ? data_second : data_first;
        end else if (run_req && dec_req.op == op_invalidate) begin
            exe_valid = 1'b1;
            exe_resp.hit = hit_any;
        end else if (run_req && hit_any) begin
            exe_valid = 1'b1;
            exe_resp.hit = 1'b1;
            exe_resp.data = hit_second ? data_second : data_first;
        end
    end

    // refill sequence
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_run;
        end else begin
            case (state)
                st_run: if (run_req && dec_req.op == op_read && !hit_any) state <= st_refill_req;
                st_refill_req: state <= st_refill_wait;
                st_refill_wait: if (last_word) state <= st_replay;
                default: state <= st_run;
            endcase
        end
    end

    // capture the missed read and its victim at the lookup
    always_ff @(posedge clk) begin
        if (run_req && dec_req.op == op_read && !hit_any) begin
            miss_req <= dec_req.fields;
            miss_way <= victim;
        end
    end

    assign stall = state != st_run;
    assign mem_req = state == st_refill_req;
    assign mem_block_addr = {miss_req.tag, miss_req.set};

    // a fill never leaves two ways of one set with the same tag
    a_one_way_hits: assert property (
        @(posedge clk) disable iff (rst)
        run_req |-> !(hit_first && hit_second)
    );

    // memory only answers a request that execute is waiting on
    a_fill_in_wait: assert property (
        @(posedge clk) disable iff (rst)
        mem_valid |-> state == st_refill_wait
    );

endmodule

`default_nettype wire

/* logic/cache_result.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_result (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             exe_valid,
    input  cache_pkg::cache_resp_t exe_resp,
    output logic                  resp_valid,
    output cache_pkg::cache_resp_t resp
);
    import cache_pkg::*;

    // last response, held between strobes
    cache_resp_t resp_q;

    // response strobe toward the processor
    // one cycle high per execute strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= exe_valid;
        end
    end

    // response word and hit flag
    // only updated when execute delivers a new response
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_q <= '0;
        end else if (exe_valid) begin
            resp_q <= exe_resp;
        end
    end

    assign resp = resp_q;

endmodule

`default_nettype wire

/* logic/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              req_valid,
    input  cache_pkg::cache_req_t  req,
    output logic                   busy,
    output logic                   resp_valid,
    output cache_pkg::cache_resp_t resp,
    output logic                   mem_req,
    output logic [cache_pkg::tag_bits+cache_pkg::set_bits-1:0] mem_block_addr,
    input  wire logic              mem_valid,
    input  cache_pkg::mem_fill_t   mem_fill
);
    import cache_pkg::*;

    // decode to execute
    logic dec_valid;
    decoded_req_t dec_req;

    // execute to result
    logic exe_valid;
    cache_resp_t exe_resp;

    // the execute stall doubles as busy toward the processor
    cache_decode u_decode (
        .clk, .rst, .req_valid, .req,
        .stall(busy),
        .dec_valid, .dec_req
    );

    cache_execute u_execute (
        .clk, .rst, .dec_valid, .dec_req,
        .stall(busy),
        .exe_valid, .exe_resp,
        .mem_req, .mem_block_addr, .mem_valid, .mem_fill
    );

    cache_result u_result (
        .clk, .rst, .exe_valid, .exe_resp,
        .resp_valid, .resp
    );

endmodule

`default_nettype wire

/* dv/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int num_directed = 24;
    localparam int num_random = 150;
    // worst refill is about 52 cycles, so 60 per request leaves margin
    localparam int timeout_cycles = (num_directed + num_random) * 60 + 200;

    logic clk;
    logic rst;
    logic req_valid;
    cache_req_t req;
    logic busy;
    logic resp_valid;
    cache_resp_t resp;
    logic mem_req;
    logic [tag_bits+set_bits-1:0] mem_block_addr;
    logic mem_valid;
    mem_fill_t mem_fill;

    int cycle = 0;
    int value_errors = 0;
    int proto_errors = 0;
    logic [31:0] stim_rng = 32'd55;
    logic [31:0] mem_rng = 32'd55 ^ 32'h9e3779b9;

    // expected responses in issue order
    // a latency reference of -1 means unchecked
    cache_resp_t exp_resp_q[$];
    string exp_name_q[$];
    int exp_cycle_q[$];
    // expected refill block addresses with one entry per model miss
    logic [tag_bits+set_bits-1:0] mem_addr_q[$];
    string mem_name_q[$];

    // reference copy of the tag store
    logic ref_valid [2][num_sets];
    logic [tag_bits-1:0] ref_tag [2][num_sets];
    logic ref_lru [2][num_sets];

    logic [tag_bits-1:0] tag_pool [3] = '{6'd5, 6'd17, 6'd42};
    logic [set_bits-1:0] set_pool [4] = '{6'd3, 6'd10, 6'd33, 6'd63};

    cache_top DUT (
        .clk, .rst, .req_valid, .req, .busy, .resp_valid, .resp,
        .mem_req, .mem_block_addr, .mem_valid, .mem_fill
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int unsigned pick_stim(input int unsigned range);
        stim_rng = xorshift(stim_rng);
        return stim_rng % range;
    endfunction

    function automatic int unsigned pick_delay();
        mem_rng = xorshift(mem_rng);
        return mem_rng % 6;
    endfunction

    // backing memory contents
    // an odd multiplier keeps every address distinct
    function automatic logic [data_bits-1:0] mem_word(input logic [addr_bits-1:0] addr);
        return 16'({1'b0, addr} * 16'h9e37) ^ 16'h3c5a;
    endfunction

    function automatic logic [addr_bits-1:0] make_addr(input logic [tag_bits-1:0] tag,
                                                       input logic [set_bits-1:0] set_idx,
                                                       input logic [word_bits-1:0] word);
        return {tag, set_idx, word};
    endfunction

    // expected response of one request
    // also updates the reference tag store
    function automatic cache_resp_t ref_access(input req_op_e op,
                                               input logic [addr_bits-1:0] addr,
                                               output logic miss);
        logic [tag_bits-1:0] tag;
        logic [set_bits-1:0] set_idx;
        logic h0;
        logic h1;
        logic way;
        cache_resp_t r;
        tag = addr[addr_bits-1 -: tag_bits];
        set_idx = addr[word_bits +: set_bits];
        h0 = ref_valid[0][set_idx] && ref_tag[0][set_idx] == tag;
        h1 = ref_valid[1][set_idx] && ref_tag[1][set_idx] == tag;
        miss = 1'b0;
        r = '0;
        if (op == op_invalidate) begin
            // both ways dropped while the first way keeps its lru bit
            r.hit = h0 || h1;
            ref_valid[0][set_idx] = 1'b0;
            ref_valid[1][set_idx] = 1'b0;
            ref_lru[1][set_idx] = ~ref_lru[0][set_idx];
        end else if (h0 || h1) begin
            r.hit = 1'b1;
            r.data = mem_word(addr);
            // the way that was not used turns into the victim
            ref_lru[0][set_idx] = h1;
            ref_lru[1][set_idx] = ~h1;
        end else begin
            miss = 1'b1;
            if (!ref_valid[0][set_idx]) way = 1'b0;
            else if (!ref_valid[1][set_idx]) way = 1'b1;
            else if (ref_lru[0][set_idx]) way = 1'b0;
            else if (ref_lru[1][set_idx]) way = 1'b1;
            else way = 1'b0;
            ref_valid[way][set_idx] = 1'b1;
            ref_tag[way][set_idx] = tag;
            ref_lru[0][set_idx] = way;
            ref_lru[1][set_idx] = ~way;
            // a miss is answered with hit low and the refilled word
            r.data = mem_word(addr);
        end
        return r;
    endfunction

    task automatic check_resp(input string name, input cache_resp_t exp, input cache_resp_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected hit=%0b data=%h, actual hit=%0b data=%h",
                     name, exp.hit, exp.data, act.hit, act.data);
            value_errors++;
        end
    endtask

    task automatic check_mem_addr(input string name,
                                  input logic [tag_bits+set_bits-1:0] exp,
                                  input logic [tag_bits+set_bits-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s mem_block_addr: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_busy(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s busy: expected %0b, actual %0b", name, exp, act);
            value_errors++;
        end
    endtask

    // one request on the next free falling edge
    // the model runs in issue order
    task automatic issue(input string name, input req_op_e op,
                         input logic [addr_bits-1:0] addr, input bit check_lat);
        cache_resp_t exp;
        logic miss;
        @(negedge clk);
        req_valid = 1'b0;
        while (busy) @(negedge clk);
        exp = ref_access(op, addr, miss);
        req_valid = 1'b1;
        req = '{op: op, addr: addr};
        exp_resp_q.push_back(exp);
        exp_name_q.push_back(name);
        exp_cycle_q.push_back(check_lat ? cycle : -1);
        if (miss) begin
            mem_addr_q.push_back(addr[addr_bits-1 -: tag_bits+set_bits]);
            mem_name_q.push_back(name);
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_resp_q.size() != 0) @(negedge clk);
        idle_cycle();
    endtask

    // compare each response against the head of the expected queue
    initial begin
        cache_resp_t exp;
        string name;
        int issued;
        forever begin
            @(negedge clk);
            if (!rst && resp_valid) begin
                if (exp_resp_q.size() == 0) begin
                    $display("response at cycle %0d with no request outstanding", cycle);
                    proto_errors++;
                end else begin
                    exp = exp_resp_q.pop_front();
                    name = exp_name_q.pop_front();
                    issued = exp_cycle_q.pop_front();
                    check_resp(name, exp, resp);
                    // any refill has finished by the time a response is registered
                    check_busy(name, 1'b0, busy);
                    if (issued >= 0 && cycle - issued != 2) begin
                        $display("[ERROR] %s latency: expected 2, actual %0d",
                                 name, cycle - issued);
                        value_errors++;
                    end
                end
            end
        end
    end

    // every mem_req must belong to a miss of the model
    initial begin
        string name;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                if (mem_addr_q.size() == 0) begin
                    $display("mem_req at cycle %0d for block %h with no miss expected",
                             cycle, mem_block_addr);
                    proto_errors++;
                end else begin
                    name = mem_name_q.pop_front();
                    check_mem_addr(name, mem_addr_q.pop_front(), mem_block_addr);
                    // busy rises in the cycle after the miss lookup
                    check_busy(name, 1'b1, busy);
                end
            end
        end
    end

    // backing memory sends eight words in order with 0 to 5 idle cycles before each
    initial begin
        logic [tag_bits+set_bits-1:0] blk;
        int d;
        mem_valid = 1'b0;
        mem_fill = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                blk = mem_block_addr;
                // next edge moves execute into st_refill_wait
                @(negedge clk);
                for (int w = 0; w < words_per_block; w++) begin
                    d = pick_delay();
                    mem_valid = 1'b0;
                    repeat (d) @(negedge clk);
                    mem_valid = 1'b1;
                    mem_fill = '{word: word_bits'(w), data: mem_word({blk, word_bits'(w)})};
                    @(negedge clk);
                end
                mem_valid = 1'b0;
            end
        end
    end

    initial begin
        while (cycle < timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, %0d responses never arrived",
                 cycle, exp_resp_q.size());
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [tag_bits-1:0] tag;
        logic [set_bits-1:0] set_idx;
        req_op_e op;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < 2; w++) begin
                ref_valid[w][s] = 1'b0;
                ref_tag[w][s] = '0;
                ref_lru[w][s] = 1'b0;
            end
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_busy("reset", 1'b0, busy);

        // cold reads where each set misses once
        for (int s = 0; s < 4; s++) begin
            issue("cold_miss", op_read, make_addr(6'(s + 1), 6'(s), 3'(s)), 1'b0);
        end
        drain();

        // back to back hits on the filled blocks
        for (int i = 0; i < 6; i++) begin
            issue("repeat_hit", op_read, make_addr(6'(i % 4 + 1), 6'(i % 4), 3'(7 - i)), 1'b1);
        end
        drain();

        // two tags share set 10 and a third one evicts the lru way
        issue("lru_fill", op_read, make_addr(6'd7, 6'd10, 3'd0), 1'b0);
        issue("lru_fill", op_read, make_addr(6'd8, 6'd10, 3'd1), 1'b0);
        drain();
        for (int i = 0; i < 4; i++) begin
            issue("lru_alternate", op_read, make_addr(i % 2 ? 6'd8 : 6'd7, 6'd10, 3'(i)), 1'b1);
        end
        drain();
        issue("lru_evict", op_read, make_addr(6'd9, 6'd10, 3'd2), 1'b0);
        issue("lru_survivor", op_read, make_addr(6'd8, 6'd10, 3'd3), 1'b0);
        issue("lru_evicted", op_read, make_addr(6'd7, 6'd10, 3'd4), 1'b0);
        drain();

        // invalidates answer like hits and the set refills afterwards
        issue("invalidate", op_invalidate, make_addr(6'd8, 6'd10, 3'd0), 1'b1);
        issue("invalidate", op_invalidate, make_addr(6'd3, 6'd20, 3'd0), 1'b1);
        drain();
        issue("after_invalidate", op_read, make_addr(6'd8, 6'd10, 3'd5), 1'b0);
        issue("after_invalidate", op_read, make_addr(6'd7, 6'd10, 3'd6), 1'b0);
        issue("after_invalidate", op_read, make_addr(6'd8, 6'd10, 3'd7), 1'b0);
        drain();

        // mixed stream over a small pool so sets conflict
        for (int i = 0; i < num_random; i++) begin
            tag = tag_pool[pick_stim(3)];
            set_idx = set_pool[pick_stim(4)];
            op = (pick_stim(8) == 0) ? op_invalidate : op_read;
            if (pick_stim(4) == 0) idle_cycle();
            issue("random", op, make_addr(tag, set_idx, 3'(pick_stim(8))), 1'b0);
        end
        drain();
        // late or duplicated responses would show up here
        repeat (10) idle_cycle();

        if (mem_addr_q.size() != 0) begin
            $display("%0d expected refills never issued mem_req", mem_addr_q.size());
            proto_errors++;
        end
        $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
logic/cache_pkg.sv
logic/meta_data_array.sv
logic/block_data_array.sv
logic/cache_decode.sv
logic/cache_execute.sv
logic/cache_result.sv
logic/cache_top.sv
dv/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  # package first, then leaf arrays, then pipeline stages and top
  - logic/cache_pkg.sv
  - logic/meta_data_array.sv
  - logic/block_data_array.sv
  - logic/cache_decode.sv
  - logic/cache_execute.sv
  - logic/cache_result.sv
  - logic/cache_top.sv

  - target: test
    files:
      - dv/cache_tb.sv
